// File: tb.f
+incdir+hw
+incdir+sim
hw/dallanma_pkg.sv
hw/dal_yurutme_asamasi.sv
hw/dallanma_birimi.sv
hw/dal_tahmin_tablosu.sv
hw/dal_sonuc_asamasi.sv
hw/dal_alt_sistem.sv
sim/tb_dal_alt_sistem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the branch path testbench with Verilator and runs it.
# The exit status is the simulator's own.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    --top-module tb_dal_alt_sistem \
    -f tb.f \
    --Mdir obj_dir \
    -o tb_dal_alt_sistem
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/tb_dal_alt_sistem
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation ended with status $sim_status"
    exit "$sim_status"
fi

exit 0

// File: sim/dal_referans_model.svh
`ifndef DAL_REFERANS_MODEL_SVH
`define DAL_REFERANS_MODEL_SVH

// Cycle model of the branch path that is stepped once on every rising edge
localparam int MODEL_SATIR_BIT = $clog2(`BHT_SATIR);

sayac_t   model_tablo [`BHT_SATIR];

// The first slot of the two-deep pipe holds the op in the issue register
uop_dal_e hat_kod;
ps_t      hat_ps;
veri_t    hat_rs1;
veri_t    hat_rs2;
veri_t    hat_anlik;
logic     hat_tahmin;

// The second slot holds what the output register should show
logic     bek_yonlendir;
ps_t      bek_yonlendir_ps;
logic     bek_baglanti;
ps_t      bek_baglanti_deger;
logic     bek_guncelle;
ps_t      bek_guncelle_ps;
logic     bek_guncelle_atladi;

int       ezilen_sayisi;

function automatic logic [MODEL_SATIR_BIT-1:0] model_satir(ps_t ps);
    return ps[MODEL_SATIR_BIT+1:2];
endfunction

function automatic logic model_yon(uop_dal_e kod, veri_t rs1, veri_t rs2);
    case (kod)
        UOP_DAL_BEQ:  return rs1 == rs2;
        UOP_DAL_BNE:  return rs1 != rs2;
        UOP_DAL_BLT:  return $signed(rs1) < $signed(rs2);
        UOP_DAL_BGE:  return !($signed(rs1) < $signed(rs2));
        UOP_DAL_BLTU: return rs1 < rs2;
        UOP_DAL_BGEU: return !(rs1 < rs2);
        UOP_DAL_JAL,
        UOP_DAL_JALR: return 1'b1;
        default:      return 1'b0;
    endcase
endfunction

task automatic model_sifirla();
    for (int i = 0; i < `BHT_SATIR; i++) begin
        model_tablo[i] = 2'd1;  // Weakly not taken
    end
    hat_kod       = UOP_DAL_YOK;
    bek_yonlendir = 1'b0;
    bek_baglanti  = 1'b0;
    bek_guncelle  = 1'b0;
endtask

task automatic model_adim(input logic gecerli, input uop_dal_e kod, input ps_t ps,
                          input veri_t rs1, input veri_t rs2, input veri_t anlik,
                          input logic tahmin);
    logic                       dal;
    logic                       yon;
    logic                       hatali;
    ps_t                        hedef;
    logic [MODEL_SATIR_BIT-1:0] satir;

    // The update shown during the last cycle trains its counter on this edge
    if (bek_guncelle) begin
        satir = model_satir(bek_guncelle_ps);
        if (bek_guncelle_atladi && model_tablo[satir] != 2'd3) begin
            model_tablo[satir] = model_tablo[satir] + 2'd1;
        end else if (!bek_guncelle_atladi && model_tablo[satir] != 2'd0) begin
            model_tablo[satir] = model_tablo[satir] - 2'd1;
        end
    end

    dal    = hat_kod != UOP_DAL_YOK;
    yon    = model_yon(hat_kod, hat_rs1, hat_rs2);
    hatali = dal && (yon != hat_tahmin);
    hedef  = hat_ps + 32'd4;
    if (yon) begin
        hedef = hat_ps + hat_anlik;
        if (hat_kod == UOP_DAL_JALR) begin
            hedef[0] = 1'b0;
        end
    end

    bek_yonlendir       = hatali;
    bek_yonlendir_ps    = hedef;
    bek_baglanti        = (hat_kod == UOP_DAL_JAL) || (hat_kod == UOP_DAL_JALR);
    bek_baglanti_deger  = hat_ps + 32'd4;
    bek_guncelle        = dal;
    bek_guncelle_ps     = hat_ps;
    bek_guncelle_atladi = yon;

    if (hatali && gecerli) begin
        ezilen_sayisi++;  // Wrong-path op is dropped
    end
    if (gecerli && !hatali) begin
        hat_kod    = kod;
        hat_ps     = ps;
        hat_rs1    = rs1;
        hat_rs2    = rs2;
        hat_anlik  = anlik;
        hat_tahmin = tahmin;
    end else begin
        hat_kod = UOP_DAL_YOK;
    end
endtask

`endif

// File: sim/tb_dal_alt_sistem.sv
`timescale 1ns/10ps

`include "dallanma_params.svh"

module tb_dal_alt_sistem;

    import dallanma_pkg::*;

    localparam int ISLEM_SAYISI   = 4000;
    localparam int BEKLEME_SINIRI = 20;

    logic     clk_i;
    logic     rst_n_i;
    logic     islem_gecerli_i;
    uop_dal_e islem_kod_i;
    ps_t      islem_ps_i;
    veri_t    islem_rs1_i;
    veri_t    islem_rs2_i;
    veri_t    islem_anlik_i;
    logic     islem_atladi_i;
    ps_t      tahmin_ps_i;
    logic     tahmin_atla_o;
    logic     yonlendir_gecerli_o;
    ps_t      yonlendir_ps_o;
    logic     baglanti_gecerli_o;
    ps_t      baglanti_deger_o;
    logic     guncelle_gecerli_o;
    ps_t      guncelle_ps_o;
    logic     guncelle_atladi_o;

    integer   tohum;
    string    test_adi;
    int       yonlendir_sayisi;
    int       baglanti_sayisi;
    int       bekleme;

    `include "dal_referans_model.svh"

    dal_alt_sistem DUT (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .islem_gecerli_i     (islem_gecerli_i),
        .islem_kod_i         (islem_kod_i),
        .islem_ps_i          (islem_ps_i),
        .islem_rs1_i         (islem_rs1_i),
        .islem_rs2_i         (islem_rs2_i),
        .islem_anlik_i       (islem_anlik_i),
        .islem_atladi_i      (islem_atladi_i),
        .tahmin_ps_i         (tahmin_ps_i),
        .tahmin_atla_o       (tahmin_atla_o),
        .yonlendir_gecerli_o (yonlendir_gecerli_o),
        .yonlendir_ps_o      (yonlendir_ps_o),
        .baglanti_gecerli_o  (baglanti_gecerli_o),
        .baglanti_deger_o    (baglanti_deger_o),
        .guncelle_gecerli_o  (guncelle_gecerli_o),
        .guncelle_ps_o       (guncelle_ps_o),
        .guncelle_atladi_o   (guncelle_atladi_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic hata_bitir();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic kontrol_ps(input string ad, input ps_t beklenen, input ps_t gercek);
        if (gercek !== beklenen) begin
            $display("Fail %s %s: expected %h, actual %h", test_adi, ad, beklenen, gercek);
            hata_bitir();
        end
    endtask

    task automatic kontrol_bit(input string ad, input logic beklenen, input logic gercek);
        if (gercek !== beklenen) begin
            $display("Fail %s %s: expected %b, actual %b", test_adi, ad, beklenen, gercek);
            hata_bitir();
        end
    endtask

    task automatic kontrol_sayac(input string ad, input sayac_t beklenen, input sayac_t gercek);
        if (gercek !== beklenen) begin
            $display("Fail %s %s: expected %0d, actual %0d", test_adi, ad, beklenen, gercek);
            hata_bitir();
        end
    endtask

    task automatic cikis_kontrol();
        kontrol_bit("yonlendir_gecerli", bek_yonlendir, yonlendir_gecerli_o);
        if (bek_yonlendir) begin
            kontrol_ps("yonlendir_ps", bek_yonlendir_ps, yonlendir_ps_o);
            yonlendir_sayisi++;
        end
        kontrol_bit("baglanti_gecerli", bek_baglanti, baglanti_gecerli_o);
        if (bek_baglanti) begin
            kontrol_ps("baglanti_deger", bek_baglanti_deger, baglanti_deger_o);
            baglanti_sayisi++;
        end
        kontrol_bit("guncelle_gecerli", bek_guncelle, guncelle_gecerli_o);
        if (bek_guncelle) begin
            kontrol_ps("guncelle_ps", bek_guncelle_ps, guncelle_ps_o);
            kontrol_bit("guncelle_atladi", bek_guncelle_atladi, guncelle_atladi_o);
        end
        kontrol_bit("tahmin_atla", model_tablo[model_satir(tahmin_ps_i)][1], tahmin_atla_o);
    endtask

    // Model sees what the DUT samples on this edge, then the next op goes out
    task automatic cevrim(input logic gecerli, input uop_dal_e kod, input ps_t ps,
                          input veri_t rs1, input veri_t rs2, input veri_t anlik,
                          input logic tahmin, input ps_t okuma);
        @(posedge clk_i);
        model_adim(islem_gecerli_i, islem_kod_i, islem_ps_i, islem_rs1_i, islem_rs2_i,
                   islem_anlik_i, islem_atladi_i);
        islem_gecerli_i <= gecerli;
        islem_kod_i     <= kod;
        islem_ps_i      <= ps;
        islem_rs1_i     <= rs1;
        islem_rs2_i     <= rs2;
        islem_anlik_i   <= anlik;
        islem_atladi_i  <= tahmin;
        tahmin_ps_i     <= okuma;
        @(negedge clk_i);
        cikis_kontrol();
    endtask

    task automatic rastgele_cevrim();
        logic       gecerli;
        logic [3:0] kod_no;
        ps_t        ps;
        veri_t      rs1;
        veri_t      rs2;
        veri_t      anlik;
        logic       tahmin;
        ps_t        okuma;

        gecerli = ($unsigned($random(tohum)) % 5) != 0;
        kod_no  = 4'($unsigned($random(tohum)) % 9);
        ps      = ps_t'($random(tohum));
        ps[1:0] = 2'b00;
        // Most ops land on four rows so their counters walk to both ends
        if (($unsigned($random(tohum)) % 4) != 0) begin
            ps[MODEL_SATIR_BIT+1:2] = MODEL_SATIR_BIT'($unsigned($random(tohum)) % 4);
        end
        rs1 = veri_t'($random(tohum));
        rs2 = veri_t'($random(tohum));
        if (($unsigned($random(tohum)) % 4) == 0) begin
            rs2 = rs1;
        end
        anlik  = veri_t'($random(tohum) >>> 20);  // Small signed offset that is odd at times
        tahmin = 1'($random(tohum));
        okuma  = ps_t'($random(tohum));
        okuma[MODEL_SATIR_BIT+1:2] = MODEL_SATIR_BIT'($unsigned($random(tohum)) % 8);
        cevrim(gecerli, uop_dal_e'(kod_no), ps, rs1, rs2, anlik, tahmin, okuma);
    endtask

    task automatic tablo_tara();
        logic [MODEL_SATIR_BIT-1:0] satir;
        ps_t                        okuma;

        for (int i = 0; i < `BHT_SATIR; i++) begin
            satir = MODEL_SATIR_BIT'(i);
            okuma = ps_t'($random(tohum));
            okuma[MODEL_SATIR_BIT+1:2] = satir;
            cevrim(1'b0, UOP_DAL_YOK, '0, '0, '0, '0, 1'b0, okuma);
            kontrol_sayac("sayac", model_tablo[satir], DUT.tablo.tablo_r[satir]);
        end
    endtask

    initial begin
        tohum            = 32'h8636e100;
        rst_n_i         <= 1'b0;
        islem_gecerli_i <= 1'b0;
        islem_kod_i     <= UOP_DAL_YOK;
        islem_ps_i      <= '0;
        islem_rs1_i     <= '0;
        islem_rs2_i     <= '0;
        islem_anlik_i   <= '0;
        islem_atladi_i  <= 1'b0;
        tahmin_ps_i     <= '0;
        model_sifirla();
        ezilen_sayisi    = 0;
        yonlendir_sayisi = 0;
        baglanti_sayisi  = 0;
        test_adi         = "sifirlama";

        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;

        bekleme = 0;
        @(negedge clk_i);
        while ((yonlendir_gecerli_o !== 1'b0 || baglanti_gecerli_o !== 1'b0 ||
                guncelle_gecerli_o !== 1'b0) && bekleme < BEKLEME_SINIRI) begin
            @(negedge clk_i);
            bekleme++;
        end
        if (yonlendir_gecerli_o !== 1'b0 || baglanti_gecerli_o !== 1'b0 ||
            guncelle_gecerli_o !== 1'b0) begin
            $display("Valid outputs did not go low after reset");
            hata_bitir();
        end
        tablo_tara();

        test_adi = "rastgele";
        repeat (ISLEM_SAYISI) rastgele_cevrim();

        // Let the last ops leave the pipe before the table is read back
        test_adi = "tablo_sonu";
        repeat (3) cevrim(1'b0, UOP_DAL_YOK, '0, '0, '0, '0, 1'b0, '0);
        tablo_tara();

        if (ezilen_sayisi == 0 || yonlendir_sayisi == 0 || baglanti_sayisi == 0) begin
            $display("Random stimulus never produced a squash, a redirect or a link");
            hata_bitir();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// File: hw/dal_alt_sistem.sv
`timescale 1ns/10ps

module dal_alt_sistem (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    input  logic                   islem_gecerli_i,
    input  dallanma_pkg::uop_dal_e islem_kod_i,
    input  dallanma_pkg::ps_t      islem_ps_i,
    input  dallanma_pkg::veri_t    islem_rs1_i,
    input  dallanma_pkg::veri_t    islem_rs2_i,
    input  dallanma_pkg::veri_t    islem_anlik_i,
    input  logic                   islem_atladi_i,

    input  dallanma_pkg::ps_t      tahmin_ps_i,
    output logic                   tahmin_atla_o,

    output logic                   yonlendir_gecerli_o,
    output dallanma_pkg::ps_t      yonlendir_ps_o,
    output logic                   baglanti_gecerli_o,
    output dallanma_pkg::ps_t      baglanti_deger_o,
    output logic                   guncelle_gecerli_o,
    output dallanma_pkg::ps_t      guncelle_ps_o,
    output logic                   guncelle_atladi_o
);

    import dallanma_pkg::*;

    uop_dal_e kod;
    ps_t      ps;
    veri_t    anlik;
    logic     atladi;
    logic     amb_esittir;
    logic     amb_kucuktur;
    logic     amb_kucuktur_isaretsiz;

    ps_t      g1_ps;
    logic     g1_ps_gecerli;
    ps_t      g2_ps;
    logic     g2_guncelle;
    logic     g2_atladi;
    ps_t      ps_atlamadi;

    dal_yurutme_asamasi yurutme (
        .clk_i                    (clk_i),
        .rst_n_i                  (rst_n_i),
        .islem_gecerli_i          (islem_gecerli_i),
        .islem_kod_i              (islem_kod_i),
        .islem_ps_i               (islem_ps_i),
        .islem_rs1_i              (islem_rs1_i),
        .islem_rs2_i              (islem_rs2_i),
        .islem_anlik_i            (islem_anlik_i),
        .islem_atladi_i           (islem_atladi_i),
        .temizle_i                (g1_ps_gecerli),  // Wrong-path op is dropped
        .kod_o                    (kod),
        .ps_o                     (ps),
        .anlik_o                  (anlik),
        .atladi_o                 (atladi),
        .amb_esittir_o            (amb_esittir),
        .amb_kucuktur_o           (amb_kucuktur),
        .amb_kucuktur_isaretsiz_o (amb_kucuktur_isaretsiz)
    );

    dallanma_birimi birim (
        .islem_kod_i              (kod),
        .islem_ps_i               (ps),
        .islem_anlik_i            (anlik),
        .islem_atladi_i           (atladi),
        .amb_esittir_i            (amb_esittir),
        .amb_kucuktur_i           (amb_kucuktur),
        .amb_kucuktur_isaretsiz_i (amb_kucuktur_isaretsiz),
        .g1_ps_o                  (g1_ps),
        .g1_ps_gecerli_o          (g1_ps_gecerli),
        .g2_ps_o                  (g2_ps),
        .g2_guncelle_o            (g2_guncelle),
        .g2_atladi_o              (g2_atladi),
        .g2_hatali_tahmin_o       (),
        .ps_atlamadi_o            (ps_atlamadi)
    );

    dal_sonuc_asamasi sonuc (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .g1_ps_i             (g1_ps),
        .g1_ps_gecerli_i     (g1_ps_gecerli),
        .g2_ps_i             (g2_ps),
        .g2_guncelle_i       (g2_guncelle),
        .g2_atladi_i         (g2_atladi),
        .kod_i               (kod),
        .ps_atlamadi_i       (ps_atlamadi),
        .yonlendir_gecerli_o (yonlendir_gecerli_o),
        .yonlendir_ps_o      (yonlendir_ps_o),
        .baglanti_gecerli_o  (baglanti_gecerli_o),
        .baglanti_deger_o    (baglanti_deger_o),
        .guncelle_gecerli_o  (guncelle_gecerli_o),
        .guncelle_ps_o       (guncelle_ps_o),
        .guncelle_atladi_o   (guncelle_atladi_o)
    );

    // Trained from the registered update, one cycle after it is visible
    dal_tahmin_tablosu tablo (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .tahmin_ps_i        (tahmin_ps_i),
        .tahmin_atla_o      (tahmin_atla_o),
        .guncelle_gecerli_i (guncelle_gecerli_o),
        .guncelle_ps_i      (guncelle_ps_o),
        .guncelle_atladi_i  (guncelle_atladi_o)
    );

endmodule

// File: hw/dal_sonuc_asamasi.sv
`timescale 1ns/10ps

module dal_sonuc_asamasi (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    input  dallanma_pkg::ps_t      g1_ps_i,
    input  logic                   g1_ps_gecerli_i,
    input  dallanma_pkg::ps_t      g2_ps_i,
    input  logic                   g2_guncelle_i,
    input  logic                   g2_atladi_i,
    input  dallanma_pkg::uop_dal_e kod_i,
    input  dallanma_pkg::ps_t      ps_atlamadi_i,

    output logic                   yonlendir_gecerli_o,
    output dallanma_pkg::ps_t      yonlendir_ps_o,
    output logic                   baglanti_gecerli_o,
    output dallanma_pkg::ps_t      baglanti_deger_o,
    output logic                   guncelle_gecerli_o,
    output dallanma_pkg::ps_t      guncelle_ps_o,
    output logic                   guncelle_atladi_o
);

    import dallanma_pkg::*;

    logic baglanti_cmb;

    // Only jumps write a return address
    assign baglanti_cmb = (kod_i == UOP_DAL_JAL) || (kod_i == UOP_DAL_JALR);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            yonlendir_gecerli_o <= 1'b0;
            baglanti_gecerli_o  <= 1'b0;
            guncelle_gecerli_o  <= 1'b0;
        end else begin
            yonlendir_gecerli_o <= g1_ps_gecerli_i;
            baglanti_gecerli_o  <= baglanti_cmb;
            guncelle_gecerli_o  <= g2_guncelle_i;
        end
    end

    always_ff @(posedge clk_i) begin
        yonlendir_ps_o    <= g1_ps_i;
        baglanti_deger_o  <= ps_atlamadi_i; // Link value is ps+4
        guncelle_ps_o     <= g2_ps_i;
        guncelle_atladi_o <= g2_atladi_i;
    end

endmodule

// File: hw/dal_tahmin_tablosu.sv
`timescale 1ns/10ps

`include "dallanma_params.svh"

module dal_tahmin_tablosu (
    input  logic              clk_i,
    input  logic              rst_n_i,

    input  dallanma_pkg::ps_t tahmin_ps_i,
    output logic              tahmin_atla_o,

    input  logic              guncelle_gecerli_i,
    input  dallanma_pkg::ps_t guncelle_ps_i,
    input  logic              guncelle_atladi_i
);

    import dallanma_pkg::*;

    localparam int SATIR_BIT = $clog2(`BHT_SATIR);

    sayac_t               tablo_r [`BHT_SATIR];
    logic [SATIR_BIT-1:0] tahmin_satir;
    logic [SATIR_BIT-1:0] guncelle_satir;
    sayac_t               eski_sayac;
    sayac_t               yeni_sayac;

    // RV32I ops are word aligned so bits 1:0 carry no index
    assign tahmin_satir   = tahmin_ps_i[SATIR_BIT+1:2];
    assign guncelle_satir = guncelle_ps_i[SATIR_BIT+1:2];

    // A same-cycle update is not forwarded so fetch sees the old counter
    assign tahmin_atla_o = tablo_r[tahmin_satir][1];

    assign eski_sayac = tablo_r[guncelle_satir];

    always_comb begin
        yeni_sayac = eski_sayac;
        if (guncelle_atladi_i) begin
            if (eski_sayac != SAYAC_EN_BUYUK) begin
                yeni_sayac = eski_sayac + 2'd1;
            end
        end else begin
            if (eski_sayac != SAYAC_EN_KUCUK) begin
                yeni_sayac = eski_sayac - 2'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BHT_SATIR; i++) begin
                tablo_r[i] <= SAYAC_ILK;
            end
        end else if (guncelle_gecerli_i) begin
            tablo_r[guncelle_satir] <= yeni_sayac;
        end
    end

endmodule

// File: hw/dallanma_birimi.sv
`timescale 1ns/10ps

`include "dallanma_params.svh"

module dallanma_birimi (
    input  dallanma_pkg::uop_dal_e islem_kod_i,
    input  dallanma_pkg::ps_t      islem_ps_i,
    input  dallanma_pkg::veri_t    islem_anlik_i,
    input  logic                   islem_atladi_i,

    input  logic                   amb_esittir_i,
    input  logic                   amb_kucuktur_i,
    input  logic                   amb_kucuktur_isaretsiz_i,

    output dallanma_pkg::ps_t      g1_ps_o,
    output logic                   g1_ps_gecerli_o,

    output dallanma_pkg::ps_t      g2_ps_o,
    output logic                   g2_guncelle_o,
    output logic                   g2_atladi_o,
    output logic                   g2_hatali_tahmin_o,

    output dallanma_pkg::ps_t      ps_atlamadi_o
);

    import dallanma_pkg::*;

    ps_t  ps_atladi_cmb;
    ps_t  ps_atlamadi_cmb;
    logic dallanma_cmb;
    logic atladi_cmb;
    logic hatali_cmb;
    ps_t  hedef_cmb;

    assign ps_atladi_cmb   = islem_ps_i + ps_t'(islem_anlik_i);
    assign ps_atlamadi_cmb = islem_ps_i + ps_t'(4);

    // Real direction of the held op
    always_comb begin
        dallanma_cmb = 1'b1;
        atladi_cmb   = 1'b0;

        case (islem_kod_i)
            UOP_DAL_BEQ:  atladi_cmb = amb_esittir_i;
            UOP_DAL_BNE:  atladi_cmb = !amb_esittir_i;
            UOP_DAL_BLT:  atladi_cmb = amb_kucuktur_i;
            UOP_DAL_BGE:  atladi_cmb = !amb_kucuktur_i;
            UOP_DAL_BLTU: atladi_cmb = amb_kucuktur_isaretsiz_i;
            UOP_DAL_BGEU: atladi_cmb = !amb_kucuktur_isaretsiz_i;
            UOP_DAL_JAL,
            UOP_DAL_JALR: atladi_cmb = 1'b1;
            default: begin
                dallanma_cmb = 1'b0; // A bubble has nothing to resolve
            end
        endcase
    end

    assign hatali_cmb = dallanma_cmb && (atladi_cmb != islem_atladi_i);

    // Where fetch has to go if the prediction was wrong
    always_comb begin
        hedef_cmb = '0;
        if (dallanma_cmb) begin
            if (!atladi_cmb) begin
                hedef_cmb = ps_atlamadi_cmb;
            end else if (islem_kod_i == UOP_DAL_JALR) begin
                hedef_cmb = {ps_atladi_cmb[`PS_BIT-1:1], 1'b0}; // JALR drops bit 0
            end else begin
                hedef_cmb = ps_atladi_cmb;
            end
        end
    end

    assign g1_ps_o         = hedef_cmb;
    assign g1_ps_gecerli_o = hatali_cmb;

    assign g2_ps_o            = dallanma_cmb ? islem_ps_i : '0;
    assign g2_guncelle_o      = dallanma_cmb;
    assign g2_atladi_o        = atladi_cmb;
    assign g2_hatali_tahmin_o = hatali_cmb;

    assign ps_atlamadi_o = ps_atlamadi_cmb;

endmodule

// File: hw/dal_yurutme_asamasi.sv
`timescale 1ns/10ps

module dal_yurutme_asamasi (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    input  logic                   islem_gecerli_i,
    input  dallanma_pkg::uop_dal_e islem_kod_i,
    input  dallanma_pkg::ps_t      islem_ps_i,
    input  dallanma_pkg::veri_t    islem_rs1_i,
    input  dallanma_pkg::veri_t    islem_rs2_i,
    input  dallanma_pkg::veri_t    islem_anlik_i,
    input  logic                   islem_atladi_i,

    input  logic                   temizle_i,

    output dallanma_pkg::uop_dal_e kod_o,
    output dallanma_pkg::ps_t      ps_o,
    output dallanma_pkg::veri_t    anlik_o,
    output logic                   atladi_o,

    output logic                   amb_esittir_o,
    output logic                   amb_kucuktur_o,
    output logic                   amb_kucuktur_isaretsiz_o
);

    import dallanma_pkg::*;

    uop_dal_e kod_r;
    ps_t      ps_r;
    veri_t    rs1_r;
    veri_t    rs2_r;
    veri_t    anlik_r;
    logic     atladi_r;

    // The held op turns into a bubble when the one ahead of it redirects fetch
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            kod_r <= UOP_DAL_YOK;
        end else if (temizle_i || !islem_gecerli_i) begin
            kod_r <= UOP_DAL_YOK;
        end else begin
            kod_r <= islem_kod_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (islem_gecerli_i) begin
            ps_r     <= islem_ps_i;
            rs1_r    <= islem_rs1_i;
            rs2_r    <= islem_rs2_i;
            anlik_r  <= islem_anlik_i;
            atladi_r <= islem_atladi_i;
        end
    end

    assign kod_o    = kod_r;
    assign ps_o     = ps_r;
    assign anlik_o  = anlik_r;
    assign atladi_o = atladi_r;

    // Comparator feeding the branch unit
    assign amb_esittir_o            = rs1_r == rs2_r;
    assign amb_kucuktur_o           = $signed(rs1_r) < $signed(rs2_r);
    assign amb_kucuktur_isaretsiz_o = rs1_r < rs2_r;

endmodule

// File: hw/dallanma_pkg.sv
`include "dallanma_params.svh"

package dallanma_pkg;

    // Branch micro-op codes as delivered by decode
    typedef enum logic [3:0] {
        UOP_DAL_YOK  = 4'd0,    // Not a branch
        UOP_DAL_BEQ  = 4'd1,
        UOP_DAL_BNE  = 4'd2,
        UOP_DAL_BLT  = 4'd3,
        UOP_DAL_BGE  = 4'd4,
        UOP_DAL_BLTU = 4'd5,
        UOP_DAL_BGEU = 4'd6,
        UOP_DAL_JAL  = 4'd7,
        UOP_DAL_JALR = 4'd8
    } uop_dal_e;

    typedef logic [`PS_BIT-1:0]   ps_t;
    typedef logic [`VERI_BIT-1:0] veri_t;

    // Values 0 and 1 predict not taken, 2 and 3 predict taken
    typedef logic [1:0] sayac_t;

    // Weakly not taken
    localparam sayac_t SAYAC_ILK = 2'd1;

    localparam sayac_t SAYAC_EN_KUCUK = 2'd0;
    localparam sayac_t SAYAC_EN_BUYUK = 2'd3;

endpackage

// File: hw/dallanma_params.svh
`ifndef DALLANMA_PARAMS_SVH
`define DALLANMA_PARAMS_SVH

// Program counter width
`define PS_BIT      32

// Operand and immediate width
`define VERI_BIT    32

// Number of 2-bit direction counters which has to be a power of two
`define BHT_SATIR   64

`endif
